/* tb/game_cases.txt */
# name command args; cfg addr data, start shape, move dir, wait cycles
# expect frame_hex ok lines, over game_over
reset_state expect 0 0 0
spawn_bar start bar
spawn_bar expect 248 0 0
shift_right move right
shift_right expect 49 1 0
wall_right move right
wall_right expect 49 0 0
drop_one move down
drop_one expect 248000 1 0
drop_bottom move down
drop_bottom move down
drop_bottom move down
drop_bottom expect 49000000000000000 1 0
lock_bar move down
lock_bar wait 2
lock_bar expect 49000000000000000 0 0
spawn_ell start ell
spawn_ell expect 49000000000480010 0 0
rot_ell move ror
rot_ell expect 49000000000080090 1 0
unrot_ell move rol
unrot_ell expect 49000000000480010 1 0
shift_left move left
shift_left move left
shift_left expect 49000000012000400 1 0
drop_ell move down
drop_ell move down
drop_ell move down
drop_ell expect 2449080000000000000 1 0
blocked_right move right
blocked_right expect 2449080000000000000 0 0
clear_row move down
clear_row wait 2
clear_row expect 400000000000000000 0 1
gravity cfg 0 4
gravity cfg 1 1
gravity start bar
gravity wait 40
gravity expect 400049000000000000 0 1
stack_bar cfg 1 0
stack_bar start bar
stack_bar move ror
stack_bar move down
stack_bar wait 2
game_over start bar
game_over wait 2
game_over expect 400049000200040008 0 1
game_over over 1
restart start bar
restart wait 2
restart expect 248 0 0
restart over 0

/* sim.f */
+incdir+logic
logic/block_pkg.sv
logic/tracker.sv
logic/row_clear.sv
logic/game_cfg.sv
logic/game_ctrl.sv
logic/game_top.sv
tb/game_chk.sv
tb/tb_game.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_game
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "PASS: all tests" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_game.sv */
`timescale 1ns/100ps

module tb_game;
  import block_pkg::*;

  localparam int CLK_HALF     = 20;
  localparam int CMD_BUDGET   = 10; // Cycles allowed per command
  localparam int RESP_TIMEOUT = 4;

  logic       clk_i;
  logic       rst_n_i;
  logic       cfg_wr_stb_i;
  logic       cfg_addr_i;
  logic [7:0] cfg_wdata_i;
  logic       start_stb_i;
  shape_t     shape_i;
  logic       move_stb_i;
  move_t      move_i;
  frame_t     frame_o;
  logic       move_done_o;
  logic       move_ok_o;
  logic       game_over_o;
  logic [7:0] lines_o;

  int          frame_errs;
  int          bit_errs;
  int          lines_errs;
  int          other_errs;
  logic [15:0] lfsr_q;
  string       cases[$];
  int          limit_cycles;

  game_top dut0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_wr_stb_i (cfg_wr_stb_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .start_stb_i  (start_stb_i),
    .shape_i      (shape_i),
    .move_stb_i   (move_stb_i),
    .move_i       (move_i),
    .frame_o      (frame_o),
    .move_done_o  (move_done_o),
    .move_ok_o    (move_ok_o),
    .game_over_o  (game_over_o),
    .lines_o      (lines_o)
  );

  always #CLK_HALF clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Idle gaps from a 16 bit LFSR, taps 16 14 13 11

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic take_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
  endfunction

  task automatic idle_gap();
    logic [1:0] n;
    n[1] = take_bit();
    n[0] = take_bit();
    repeat (n) @(posedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_frame(input string name, input frame_t exp, input frame_t act);
    if (act !== exp) begin
      $display("mismatch %s: frame expected %h actual %h", name, exp, act);
      frame_errs++;
    end
  endtask

  task automatic check_ok(input string name, input string what, input logic exp,
                          input logic act);
    if (act !== exp) begin
      $display("mismatch %s: %s expected %b actual %b", name, what, exp, act);
      bit_errs++;
    end
  endtask

  task automatic check_lines(input string name, input logic [7:0] exp,
                             input logic [7:0] act);
    if (act !== exp) begin
      $display("mismatch %s: lines expected %0d actual %0d", name, exp, act);
      lines_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Strobe drivers

  task automatic write_cfg(input logic addr, input logic [7:0] data);
    @(posedge clk_i);
    cfg_wr_stb_i <= 1'b1;
    cfg_addr_i   <= addr;
    cfg_wdata_i  <= data;
    @(posedge clk_i);
    cfg_wr_stb_i <= 1'b0;
    idle_gap();
  endtask

  task automatic start_piece(input shape_t s);
    @(posedge clk_i);
    start_stb_i <= 1'b1;
    shape_i     <= s;
    @(posedge clk_i);
    start_stb_i <= 1'b0;
    idle_gap();
  endtask

  task automatic send_move(input string name, input move_t m);
    bit got;
    @(posedge clk_i);
    move_stb_i <= 1'b1;
    move_i     <= m;
    @(posedge clk_i);
    move_stb_i <= 1'b0;
    got = 0;
    for (int i = 0; i < RESP_TIMEOUT && !got; i++) begin
      @(negedge clk_i);
      got = move_done_o;
    end
    if (!got) begin
      $display("%s: the move strobe was never answered by move_done_o", name);
      other_errs++;
    end
    idle_gap();
  endtask

  ////////////////////////////////////////////////////////////
  // Command interpreter

  task automatic verify_field_count(input string name, input int got, input int want);
    if (got != want) begin
      $display("%s: case file line has %0d fields where %0d are needed", name, got, want);
      other_errs++;
    end
  endtask

  task automatic run_line(input string line);
    string      name;
    string      op;
    string      arg;
    frame_t     exp_frame;
    int         a;
    int         b;
    int         cnt;
    cnt = $sscanf(line, "%s %s", name, op);
    case (op)
      "cfg": begin
        cnt = $sscanf(line, "%s %s %d %d", name, op, a, b);
        verify_field_count(name, cnt, 4);
        write_cfg(a[0], b[7:0]);
      end
      "start", "move": begin
        cnt = $sscanf(line, "%s %s %s", name, op, arg);
        verify_field_count(name, cnt, 3);
        case (arg)
          "bar":   start_piece(SH_BAR);
          "ell":   start_piece(SH_ELL);
          "skew":  start_piece(SH_SKEW);
          "right": send_move(name, RIGHT);
          "left":  send_move(name, LEFT);
          "ror":   send_move(name, ROR);
          "rol":   send_move(name, ROL);
          "down":  send_move(name, DOWN);
          default: begin
            $display("%s: unknown argument %s in case file", name, arg);
            other_errs++;
          end
        endcase
      end
      "wait": begin
        cnt = $sscanf(line, "%s %s %d", name, op, a);
        verify_field_count(name, cnt, 3);
        repeat (a) @(posedge clk_i);
      end
      "expect": begin
        cnt = $sscanf(line, "%s %s %h %d %d", name, op, exp_frame, a, b);
        verify_field_count(name, cnt, 5);
        @(negedge clk_i); // Outputs settled
        check_frame(name, exp_frame, frame_o);
        check_ok(name, "move_ok", a[0], move_ok_o);
        check_lines(name, b[7:0], lines_o);
      end
      "over": begin
        cnt = $sscanf(line, "%s %s %d", name, op, a);
        verify_field_count(name, cnt, 3);
        @(negedge clk_i);
        check_ok(name, "game_over", a[0], game_over_o);
      end
      default: begin
        $display("%s: unknown command %s in case file", name, op);
        other_errs++;
      end
    endcase
  endtask

  initial begin
    int    fd;
    int    n;
    int    a;
    string line;
    string name;
    string op;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    cfg_wr_stb_i = 1'b0;
    cfg_addr_i   = 1'b0;
    cfg_wdata_i  = '0;
    start_stb_i  = 1'b0;
    shape_i      = SH_BAR;
    move_stb_i   = 1'b0;
    move_i       = DOWN;
    frame_errs   = 0;
    bit_errs     = 0;
    lines_errs   = 0;
    other_errs   = 0;
    lfsr_q       = 16'd15885;
    limit_cycles = 50; // Reset and margin

    fd = $fopen("tb/game_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file tb/game_cases.txt");
      other_errs++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line.substr(0, 0) != "#") begin
          cases.push_back(line);
        end
      end
      $fclose(fd);
    end

    // Run length follows from the cases
    foreach (cases[i]) begin
      limit_cycles += CMD_BUDGET;
      if ($sscanf(cases[i], "%s %s %d", name, op, a) == 3 && op == "wait") begin
        limit_cycles += a;
      end
    end

    fork
      begin
        #(limit_cycles * 2 * CLK_HALF);
        $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
        $display("FAIL: see errors above");
        $finish;
      end
    join_none

    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    foreach (cases[i]) begin
      run_line(cases[i]);
    end

    $display("errors: frame %0d flag %0d lines %0d other %0d",
             frame_errs, bit_errs, lines_errs, other_errs);
    if (frame_errs + bit_errs + lines_errs + other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* tb/game_chk.sv */
`timescale 1ns/100ps

module game_chk (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   start_stb_i,
  input logic                   move_stb_i,
  input block_pkg::game_state_t state_i,
  input logic                   move_done_i,
  input logic                   game_over_i,
  input logic [7:0]             lines_i
);
  import block_pkg::*;

  // Every move taken in play is answered on the next cycle
  move_answered: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (move_stb_i && state_i == G_ACTIVE) |=> move_done_i)
    else $error("move strobe in active state not answered");

  // No answer without a request
  done_has_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    move_done_i |-> $past(move_stb_i))
    else $error("move_done_o without a move strobe");

  over_not_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(game_over_i && move_done_i))
    else $error("game_over_o and move_done_o both high");

  // Line count only drops on a restart
  lines_monotonic: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (lines_i < $past(lines_i)) |-> $past(start_stb_i))
    else $error("lines_o decreased without a start strobe");

endmodule

bind game_top game_chk chk0 (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .start_stb_i (start_stb_i),
  .move_stb_i  (move_stb_i),
  .state_i     (u_ctrl.state_q),
  .move_done_i (move_done_o),
  .game_over_i (game_over_o),
  .lines_i     (lines_o)
);

/* logic/game_top.sv */
`timescale 1ns/100ps

module game_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              cfg_wr_stb_i,
  input  logic              cfg_addr_i,
  input  logic [7:0]        cfg_wdata_i,
  input  logic              start_stb_i,
  input  block_pkg::shape_t shape_i,
  input  logic              move_stb_i,
  input  block_pkg::move_t  move_i,
  output block_pkg::frame_t frame_o,
  output logic              move_done_o,
  output logic              move_ok_o,
  output logic              game_over_o,
  output logic [7:0]        lines_o
);
  import block_pkg::*;

  cfg_t       cfg;
  move_t      trk_move;
  frame_t     ctrl_frame;  // Registered play field
  piece_t     ctrl_piece;
  logic       trk_legal;
  frame_t     trk_frame;
  piece_t     trk_piece;
  frame_t     clr_frame;
  logic [2:0] clr_rows;

  game_cfg u_cfg (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_wr_stb_i (cfg_wr_stb_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_o        (cfg)
  );

  game_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_i       (cfg),
    .start_stb_i (start_stb_i),
    .shape_i     (shape_i),
    .move_stb_i  (move_stb_i),
    .move_i      (move_i),
    .trk_legal_i (trk_legal),
    .trk_frame_i (trk_frame),
    .trk_piece_i (trk_piece),
    .clr_frame_i (clr_frame),
    .clr_rows_i  (clr_rows),
    .trk_move_o  (trk_move),
    .frame_o     (ctrl_frame),
    .piece_o     (ctrl_piece),
    .move_done_o (move_done_o),
    .move_ok_o   (move_ok_o),
    .game_over_o (game_over_o),
    .lines_o     (lines_o)
  );

  // Zero latency helpers around the controller
  tracker u_tracker (
    .frame_i (ctrl_frame),
    .piece_i (ctrl_piece),
    .move_i  (trk_move),
    .legal_o (trk_legal),
    .frame_o (trk_frame),
    .piece_o (trk_piece)
  );

  row_clear u_row_clear (
    .frame_i (ctrl_frame),
    .frame_o (clr_frame),
    .rows_o  (clr_rows)
  );

  assign frame_o = ctrl_frame;

endmodule

/* logic/game_ctrl.sv */
`timescale 1ns/100ps
`include "block_defines.svh"

module game_ctrl (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  block_pkg::cfg_t   cfg_i,
  input  logic              start_stb_i,
  input  block_pkg::shape_t shape_i,
  input  logic              move_stb_i,
  input  block_pkg::move_t  move_i,
  input  logic              trk_legal_i,
  input  block_pkg::frame_t trk_frame_i,
  input  block_pkg::piece_t trk_piece_i,
  input  block_pkg::frame_t clr_frame_i,
  input  logic [2:0]        clr_rows_i,
  output block_pkg::move_t  trk_move_o,
  output block_pkg::frame_t frame_o,
  output block_pkg::piece_t piece_o,
  output logic              move_done_o,
  output logic              move_ok_o,
  output logic              game_over_o,
  output logic [7:0]        lines_o
);
  import block_pkg::*;

  localparam logic [2:0] SPAWN_COL = 3'd1;

  game_state_t state_q;
  frame_t      frame_q;
  piece_t      piece_q;
  logic [7:0]  lines_q;
  logic [7:0]  grav_cnt_q;
  logic        done_q;
  logic        ok_q;

  logic        active;
  logic        do_move;  // User move taken this cycle
  logic        grav_hit;
  logic        do_grav;  // Gravity DOWN taken this cycle
  logic        step;
  logic        do_spawn;
  logic        spawn_free;
  frame_t      spawn_base;
  frame_t      spawn_frame;
  piece_t      spawn_piece;
  logic [`BOX_DIM*`BOX_DIM-1:0] spawn_mask;

  assign active   = (state_q == G_ACTIVE);
  assign do_move  = active && move_stb_i;
  assign grav_hit = (grav_cnt_q >= cfg_i.grav_period);
  assign do_grav  = active && cfg_i.grav_en && grav_hit && !move_stb_i; // Move wins
  assign step     = do_move || do_grav;
  assign do_spawn = start_stb_i && (state_q == G_IDLE || state_q == G_OVER);

  assign trk_move_o = move_stb_i ? move_i : DOWN;

  ////////////////////////////////////////////////////////////
  // Spawn vacancy test

  assign spawn_piece = '{shape: shape_i, rot: 2'd0, row: 3'd0, col: SPAWN_COL};

  always_comb begin
    spawn_base  = (state_q == G_OVER) ? '0 : frame_q; // Restart clears the grid
    spawn_frame = spawn_base;
    spawn_free  = 1'b1;
    spawn_mask  = pose_mask(shape_i, 2'd0);
    for (int r = 0; r < `BOX_DIM; r++) begin
      for (int c = 0; c < `BOX_DIM; c++) begin
        if (spawn_mask[r*`BOX_DIM + c]) begin
          if (spawn_base[r][c + SPAWN_COL] != '0) begin
            spawn_free = 1'b0;
          end
          spawn_frame[r][c + SPAWN_COL] = shape_color(shape_i);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // State, frame and counters

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= G_IDLE;
      frame_q    <= '0;
      lines_q    <= '0;
      grav_cnt_q <= '0;
      done_q     <= 1'b0;
      ok_q       <= 1'b0;
    end else begin
      done_q <= do_move;
      if (do_move) begin
        ok_q <= trk_legal_i;
      end

      // Tick cycle counts as the first of the next period
      if (!active || !cfg_i.grav_en) begin
        grav_cnt_q <= '0;
      end else if (do_grav) begin
        grav_cnt_q <= 8'd1;
      end else if (!grav_hit) begin
        grav_cnt_q <= grav_cnt_q + 8'd1;
      end

      case (state_q)
        G_IDLE, G_OVER: begin
          if (do_spawn) begin
            if (state_q == G_OVER) begin
              lines_q <= '0;
            end
            if (spawn_free) begin
              frame_q <= spawn_frame;
              state_q <= G_ACTIVE;
            end else begin
              state_q <= G_OVER; // Frame kept as is
            end
          end
        end
        G_ACTIVE: begin
          if (step) begin
            frame_q <= trk_frame_i;
            if (trk_move_o == DOWN && !trk_legal_i) begin
              state_q <= G_LOCK; // Piece has landed
            end
          end
        end
        G_LOCK: begin
          frame_q <= clr_frame_i;
          lines_q <= lines_q + {5'd0, clr_rows_i};
          state_q <= G_IDLE;
        end
        default: state_q <= G_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_spawn) begin
      piece_q <= spawn_piece;
    end else if (step) begin
      piece_q <= trk_piece_i;
    end
  end

  assign frame_o     = frame_q;
  assign piece_o     = piece_q;
  assign move_done_o = done_q;
  assign move_ok_o   = ok_q;
  assign game_over_o = (state_q == G_OVER);
  assign lines_o     = lines_q;

endmodule

/* logic/game_cfg.sv */
`timescale 1ns/100ps
`include "block_defines.svh"

module game_cfg (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           cfg_wr_stb_i,
  input  logic           cfg_addr_i,
  input  logic [7:0]     cfg_wdata_i,
  output block_pkg::cfg_t cfg_o
);
  import block_pkg::*;

  cfg_t cfg_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q.grav_period <= `GRAV_RESET;
      cfg_q.grav_en     <= 1'b0;
    end else if (cfg_wr_stb_i) begin
      case (cfg_addr_i)
        `CFG_ADDR_GRAV: begin
          // Period of zero would stall the timer, store 1 instead
          cfg_q.grav_period <= (cfg_wdata_i == 8'd0) ? 8'd1 : cfg_wdata_i;
        end
        `CFG_ADDR_CTRL: cfg_q.grav_en <= cfg_wdata_i[0];
      endcase
    end
  end

  assign cfg_o = cfg_q;

endmodule

/* logic/row_clear.sv */
`timescale 1ns/100ps
`include "block_defines.svh"

module row_clear (
  input  block_pkg::frame_t frame_i,
  output block_pkg::frame_t frame_o,
  output logic [2:0]        rows_o
);
  import block_pkg::*;

  // Walk from the bottom up, copy surviving rows to the next free slot
  always_comb begin
    int   dst;
    logic full;
    frame_o = '0;  // Top rows left over stay empty
    rows_o  = '0;
    dst     = `GRID_ROWS - 1;
    for (int src = `GRID_ROWS - 1; src >= 0; src--) begin
      full = 1'b1;
      for (int c = 0; c < `GRID_COLS; c++) begin
        if (frame_i[src][c] == '0) begin
          full = 1'b0;
        end
      end
      if (full) begin
        rows_o = rows_o + 3'd1;
      end else begin
        frame_o[dst] = frame_i[src];
        dst          = dst - 1;
      end
    end
  end

endmodule

/* logic/tracker.sv */
`timescale 1ns/100ps
`include "block_defines.svh"

module tracker (
  input  block_pkg::frame_t frame_i,
  input  block_pkg::piece_t piece_i,
  input  block_pkg::move_t  move_i,
  output logic              legal_o,
  output block_pkg::frame_t frame_o,
  output block_pkg::piece_t piece_o
);
  import block_pkg::*;

  typedef logic [`GRID_ROWS-1:0][`GRID_COLS-1:0] occ_t;

  piece_t cand;    // Pose after the requested move
  occ_t   cur_occ;
  occ_t   new_occ;
  logic   cur_out;
  logic   new_out;
  logic   blocked;

  // Spread a pose over the grid, flag any cell that falls off it
  function automatic void expand(input piece_t p, output occ_t occ, output logic outside);
    logic [`BOX_DIM*`BOX_DIM-1:0] mask;
    logic [3:0] rr;
    logic [3:0] cc;
    mask    = pose_mask(p.shape, p.rot);
    occ     = '0;
    outside = 1'b0;
    for (int r = 0; r < `BOX_DIM; r++) begin
      for (int c = 0; c < `BOX_DIM; c++) begin
        rr = {1'b0, p.row} + 4'(r);
        cc = {1'b0, p.col} + 4'(c);
        if (mask[r*`BOX_DIM + c]) begin
          if (rr >= `GRID_ROWS || cc >= `GRID_COLS) begin
            outside = 1'b1;
          end else begin
            occ[rr[2:0]][cc[2:0]] = 1'b1;
          end
        end
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Candidate pose

  always_comb begin
    cand = piece_i;
    case (move_i)
      RIGHT:   cand.col = piece_i.col - 3'd1; // Wraps off the grid at col 0
      LEFT:    cand.col = piece_i.col + 3'd1;
      ROR:     cand.rot = piece_i.rot + 2'd1;
      ROL:     cand.rot = piece_i.rot - 2'd1;
      DOWN:    cand.row = piece_i.row + 3'd1;
      default: cand = piece_i;
    endcase
  end

  always_comb begin
    expand(piece_i, cur_occ, cur_out);
    expand(cand, new_occ, new_out);
  end

  ////////////////////////////////////////////////////////////
  // Legality and rewrite

  // Own cells count as free, the piece may overlap its old pose
  always_comb begin
    blocked = 1'b0;
    for (int r = 0; r < `GRID_ROWS; r++) begin
      for (int c = 0; c < `GRID_COLS; c++) begin
        if (new_occ[r][c] && !cur_occ[r][c] && frame_i[r][c] != '0) begin
          blocked = 1'b1;
        end
      end
    end
  end

  assign legal_o = !new_out && !cur_out && !blocked;

  always_comb begin
    frame_o = frame_i;
    if (legal_o) begin
      for (int r = 0; r < `GRID_ROWS; r++) begin
        for (int c = 0; c < `GRID_COLS; c++) begin
          if (cur_occ[r][c]) begin
            frame_o[r][c] = '0; // Lift old pose
          end
          if (new_occ[r][c]) begin
            frame_o[r][c] = shape_color(piece_i.shape);
          end
        end
      end
    end
  end

  assign piece_o = legal_o ? cand : piece_i;

endmodule

/* logic/block_pkg.sv */
`include "block_defines.svh"

package block_pkg;

  // Row 0 is the top row, col 0 sits in the low bits of a row
  typedef logic [`GRID_ROWS-1:0][`GRID_COLS-1:0][`CELL_W-1:0] frame_t;

  typedef enum logic [2:0] {
    RIGHT, // Toward col 0
    LEFT,  // Toward the high cols
    ROR,   // Rotate right
    ROL,   // Rotate left
    DOWN
  } move_t;

  typedef enum logic [1:0] {
    SH_BAR,  // Three in a line
    SH_ELL,  // Three in an L
    SH_SKEW  // Four in an S
  } shape_t;

  // Anchor is the top left corner of the pose box
  typedef struct packed {
    shape_t     shape;
    logic [1:0] rot;
    logic [2:0] row;
    logic [2:0] col;
  } piece_t;

  typedef enum logic [1:0] {
    G_IDLE,
    G_ACTIVE,
    G_LOCK,
    G_OVER
  } game_state_t;

  typedef struct packed {
    logic [7:0] grav_period;
    logic       grav_en;
  } cfg_t;

  ////////////////////////////////////////////////////////////
  // Shape tables

  function automatic logic [`CELL_W-1:0] shape_color(input shape_t s);
    case (s)
      SH_BAR:  return `CELL_W'd1;
      SH_ELL:  return `CELL_W'd2;
      SH_SKEW: return `CELL_W'd3;
      default: return '0;
    endcase
  endfunction

  // Occupied cells of a pose, bit r*BOX_DIM+c, every pose packed to the top left
  function automatic logic [`BOX_DIM*`BOX_DIM-1:0] pose_mask(input shape_t s,
                                                             input logic [1:0] rot);
    case (s)
      SH_BAR:  return rot[0] ? 9'b001_001_001 : 9'b000_000_111;
      SH_ELL: begin
        case (rot)
          2'd0:    return 9'b000_011_001;
          2'd1:    return 9'b000_001_011;
          2'd2:    return 9'b000_010_011;
          default: return 9'b000_011_010;
        endcase
      end
      SH_SKEW: return rot[0] ? 9'b010_011_001 : 9'b000_011_110;
      default: return '0;
    endcase
  endfunction

endpackage

/* logic/block_defines.svh */
`ifndef BLOCK_DEFINES_SVH
`define BLOCK_DEFINES_SVH

// Play field geometry
`define GRID_ROWS 5
`define GRID_COLS 5
`define CELL_W    3 // Zero means empty cell
`define BOX_DIM   3 // Side of the box holding one piece pose

// Configuration register map
`define CFG_ADDR_GRAV 1'b0
`define CFG_ADDR_CTRL 1'b1

`define GRAV_RESET 8'd16 // Gravity period out of reset

`endif
